/* Makefile */
VERILATOR ?= verilator
TOP ?= macro_fetch_unit_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/instruction_word_buffer.sv */
// Instruction word buffer

`timescale 1ns/10ps

module instruction_word_buffer #(
   parameter int LC_WIDTH = $bits(macro_fetch_pkg::lc_t),
   parameter int WORD_WIDTH = $bits(macro_fetch_pkg::mem_word_t)
) (
   input logic clk,
   input logic reset,
   input logic ifetch,
   lc_bus_if.reader lcb,
   output logic mem_rd,
   output logic [LC_WIDTH-3:0] mem_addr,
   input logic mem_valid,
   input logic [WORD_WIDTH-1:0] mem_data,
   output logic [WORD_WIDTH-1:0] word,
   output logic word_valid
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_REQUEST,
      S_WAITING
   } state_t;

   state_t state;
   logic [LC_WIDTH-3:0] addr_q;
   logic [LC_WIDTH-3:0] lc_word_addr;

   assign lc_word_addr = lcb.lc[LC_WIDTH-1:2];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= S_IDLE;
         word_valid <= 1'b0;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               if (ifetch)
               begin
                  state <= S_REQUEST;
                  word_valid <= 1'b0;   // drops together with mem_rd.
               end
            end
            S_REQUEST:
            begin
               state <= S_WAITING;
            end
            S_WAITING:
            begin
               if (mem_valid)
               begin
                  state <= S_IDLE;
                  word_valid <= 1'b1;
               end
            end
            default:
            begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // lc has already moved when the request goes out.
   always_ff @(posedge clk)
   begin
      if (state == S_REQUEST)
         addr_q <= lc_word_addr;
      if (state == S_WAITING && mem_valid)
         word <= mem_data;   // held until the next fetch completes.
   end

   assign mem_rd = (state == S_REQUEST);
   assign mem_addr = (state == S_REQUEST) ? lc_word_addr : addr_q;

   a_valid_when_waiting : assert property (
      @(posedge clk) disable iff (reset)
      mem_valid |-> state == S_WAITING
   ) else $error("mem_valid with no read outstanding");

   // the sequencer must wait for word_valid before fetching again.
   a_no_fetch_busy : assert property (
      @(posedge clk) disable iff (reset)
      ifetch |-> state == S_IDLE
   ) else $error("fetch while buffer busy");

endmodule

/* logic/lc_bus_if.sv */
// Location counter bus

`timescale 1ns/10ps

interface lc_bus_if #(
   parameter int LC_WIDTH = $bits(macro_fetch_pkg::lc_t)
);

   logic [LC_WIDTH-1:0] lc;      // current location counter.
   logic lc_byte_mode;           // 1 steps by bytes, 0 by halfwords.
   logic lcinc;                  // step request at the next state_fetch.
   logic needfetch;              // current word is stale or used up.

   modport ctl (
      input lc,
      input lc_byte_mode,
      output lcinc,
      output needfetch
   );

   modport counter (
      output lc,
      output lc_byte_mode,
      input lcinc
   );

   modport reader (
      input lc,
      input lc_byte_mode
   );

endinterface

/* logic/lc_control.sv */
// Location counter control

`timescale 1ns/10ps

module lc_control #(
   parameter int LC_WIDTH = $bits(macro_fetch_pkg::lc_t)
) (
   input logic clk,
   input logic reset,
   input logic state_fetch,
   input logic destlc,
   input logic irdisp,
   input logic spop,
   input logic srcspcpopreal,
   input logic ext_int,
   input logic bus_int,
   input macro_fetch_pkg::ir_t ir,
   input macro_fetch_pkg::spc_t spc,
   lc_bus_if.ctl lcb,
   output logic ifetch,
   output logic newlc,
   output logic sintr,
   output logic spc1a,
   output logic inst_in_left_half,
   output logic sh3,
   output logic sh4
);

   logic [LC_WIDTH-1:0] lc_cur;
   logic lc0b;
   logic have_wrong_word;
   logic last_byte_in_word;
   logic next_instr;
   logic next_instrd;
   logic newlc_in;
   logic spcmung;
   logic lc_modifies_mrot;
   logic inst_in_2nd_or_4th_quarter;

   assign lc_cur = lcb.lc;
   assign lc0b = lc_cur[0] & lcb.lc_byte_mode;   // odd byte, byte mode only.

   // a popped return address with the macro bit resumes macrocode.
   assign next_instr = spop & ~srcspcpopreal & spc[macro_fetch_pkg::SPC_MACRO_RETURN_BIT];

   assign have_wrong_word = newlc | destlc;
   assign last_byte_in_word = ~lc_cur[1] & ~lc0b;
   assign lcb.needfetch = have_wrong_word | last_byte_in_word;

   assign lcb.lcinc = next_instrd | (irdisp & ir[macro_fetch_pkg::IR_LCINC_BIT]);

   // strobed so the buffer sees one trigger per microinstruction.
   assign ifetch = lcb.needfetch & lcb.lcinc & state_fetch;

   // a stale word not consumed by this step stays pending.
   assign newlc_in = have_wrong_word & ~lcb.lcinc;

   assign spcmung = spc[macro_fetch_pkg::SPC_MACRO_RETURN_BIT] & ~lcb.needfetch;
   assign spc1a = spcmung | spc[1];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         newlc <= 1'b0;
         sintr <= 1'b0;
         next_instrd <= 1'b0;
      end
      else if (state_fetch)
      begin
         newlc <= newlc_in;
         sintr <= ext_int | bus_int;   // sampled at the instruction boundary.
         next_instrd <= next_instr;
      end
   end

   // Rotation adjust for the instruction position inside the word.
   // Halfword 0 is the low half, and byte order within a word runs 0, 3, 2, 1
   // from the left, so lc[1] and lc0b together decide the half.
   assign lc_modifies_mrot = ir[macro_fetch_pkg::IR_MROT_BIT_A]
                             & ir[macro_fetch_pkg::IR_MROT_BIT_B];

   assign inst_in_left_half = ~(lc_cur[1] ^ lc0b) & lc_modifies_mrot;
   assign sh4 = ir[4] ^ inst_in_left_half;

   assign inst_in_2nd_or_4th_quarter = ~lc_cur[0] & lc_modifies_mrot & lcb.lc_byte_mode;
   assign sh3 = ir[3] ^ inst_in_2nd_or_4th_quarter;

   // the sequencer loads lc only at the end of a microinstruction.
   a_destlc_with_fetch : assert property (
      @(posedge clk) disable iff (reset)
      destlc |-> state_fetch
   ) else $error("destlc outside state_fetch");

endmodule

/* logic/location_counter.sv */
// Location counter register

`timescale 1ns/10ps

module location_counter #(
   parameter int LC_WIDTH = $bits(macro_fetch_pkg::lc_t)
) (
   input logic clk,
   input logic reset,
   input logic state_fetch,
   input logic destlc,
   input logic [LC_WIDTH-1:0] lc_load_data,
   input logic byte_mode,
   lc_bus_if.counter lcb
);

   logic [LC_WIDTH-1:0] lc_q;
   logic byte_mode_q;
   logic [LC_WIDTH-1:0] lc_step;

   // one byte or one halfword per instruction.
   assign lc_step = byte_mode_q ? LC_WIDTH'(macro_fetch_pkg::LC_STEP_BYTE)
                                : LC_WIDTH'(macro_fetch_pkg::LC_STEP_HALF);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         lc_q <= '0;
         byte_mode_q <= 1'b0;
      end
      else if (state_fetch)
      begin
         if (destlc)
         begin
            lc_q <= lc_load_data;   // load wins over a step.
            byte_mode_q <= byte_mode;
         end
         else if (lcb.lcinc)
         begin
            lc_q <= lc_q + lc_step;
         end
      end
   end

   assign lcb.lc = lc_q;
   assign lcb.lc_byte_mode = byte_mode_q;

   // halfword addresses are even, which also needs an even load value.
   a_half_mode_even : assert property (
      @(posedge clk) disable iff (reset)
      !lcb.lc_byte_mode |-> !lcb.lc[0]
   ) else $error("odd lc in halfword mode");

endmodule

/* logic/macro_fetch_pkg.sv */
// Macroinstruction fetch definitions

package macro_fetch_pkg;

   // base widths of the default configuration.
   localparam int LC_W = 26;
   localparam int WORD_W = 32;
   localparam int WORD_ADDR_W = LC_W - 2;
   localparam int MACRO_INSTR_W = WORD_W / 2;
   localparam int IR_W = 49;
   localparam int SPC_W = 19;

   typedef logic [LC_W-1:0] lc_t;                 // halfword or byte address.
   typedef logic [WORD_W-1:0] mem_word_t;
   typedef logic [WORD_ADDR_W-1:0] word_addr_t;   // lc without its low two bits.
   typedef logic [MACRO_INSTR_W-1:0] macro_instr_t;
   typedef logic [IR_W-1:0] ir_t;
   typedef logic [SPC_W-1:0] spc_t;

   // microinstruction and stack bits seen by the lc control.
   localparam int IR_LCINC_BIT = 24;         // dispatch also steps the lc.
   localparam int IR_MROT_BIT_A = 10;
   localparam int IR_MROT_BIT_B = 11;        // both set means lc-relative rotation.
   localparam int SPC_MACRO_RETURN_BIT = 14;

   // instruction select rule.
   localparam int BYTES_PER_WORD = 4;        // indexed by lc[1:0], byte 0 lowest.
   localparam int HALVES_PER_WORD = 2;       // indexed by lc[1], half 0 lowest.
   localparam int LC_STEP_BYTE = 1;
   localparam int LC_STEP_HALF = 2;

endpackage

/* logic/macro_fetch_unit.sv */
// Macroinstruction fetch unit

`timescale 1ns/10ps

module macro_fetch_unit #(
   parameter int LC_WIDTH = $bits(macro_fetch_pkg::lc_t),
   parameter int WORD_WIDTH = $bits(macro_fetch_pkg::mem_word_t)
) (
   input logic clk,
   input logic reset,
   input logic state_fetch,
   input logic destlc,
   input logic [LC_WIDTH-1:0] lc_load_data,
   input logic byte_mode,
   input logic irdisp,
   input logic spop,
   input logic srcspcpopreal,
   input logic ext_int,
   input logic bus_int,
   input macro_fetch_pkg::ir_t ir,
   input macro_fetch_pkg::spc_t spc,
   input logic mem_valid,
   input logic [WORD_WIDTH-1:0] mem_data,
   output logic mem_rd,
   output logic [LC_WIDTH-3:0] mem_addr,
   output logic [WORD_WIDTH/2-1:0] macro_instr,
   output logic word_valid,
   output logic [LC_WIDTH-1:0] lc,
   output logic needfetch,
   output logic lcinc,
   output logic ifetch,
   output logic newlc,
   output logic sintr,
   output logic spc1a,
   output logic inst_in_left_half,
   output logic sh3,
   output logic sh4
);

   logic [WORD_WIDTH-1:0] word;

   lc_bus_if #(.LC_WIDTH(LC_WIDTH)) lcb ();

   lc_control #(
      .LC_WIDTH(LC_WIDTH)
   ) u_lc_control (
      .clk(clk),
      .reset(reset),
      .state_fetch(state_fetch),
      .destlc(destlc),
      .irdisp(irdisp),
      .spop(spop),
      .srcspcpopreal(srcspcpopreal),
      .ext_int(ext_int),
      .bus_int(bus_int),
      .ir(ir),
      .spc(spc),
      .lcb(lcb.ctl),
      .ifetch(ifetch),
      .newlc(newlc),
      .sintr(sintr),
      .spc1a(spc1a),
      .inst_in_left_half(inst_in_left_half),
      .sh3(sh3),
      .sh4(sh4)
   );

   location_counter #(
      .LC_WIDTH(LC_WIDTH)
   ) u_location_counter (
      .clk(clk),
      .reset(reset),
      .state_fetch(state_fetch),
      .destlc(destlc),
      .lc_load_data(lc_load_data),
      .byte_mode(byte_mode),
      .lcb(lcb.counter)
   );

   instruction_word_buffer #(
      .LC_WIDTH(LC_WIDTH),
      .WORD_WIDTH(WORD_WIDTH)
   ) u_word_buffer (
      .clk(clk),
      .reset(reset),
      .ifetch(ifetch),
      .lcb(lcb.reader),
      .mem_rd(mem_rd),
      .mem_addr(mem_addr),
      .mem_valid(mem_valid),
      .mem_data(mem_data),
      .word(word),
      .word_valid(word_valid)
   );

   macro_instr_select #(
      .LC_WIDTH(LC_WIDTH),
      .WORD_WIDTH(WORD_WIDTH)
   ) u_instr_select (
      .lcb(lcb.reader),
      .word(word),
      .macro_instr(macro_instr)
   );

   // lc group seen from outside.
   assign lc = lcb.lc;
   assign needfetch = lcb.needfetch;
   assign lcinc = lcb.lcinc;

endmodule

/* logic/macro_instr_select.sv */
// Macroinstruction selector

`timescale 1ns/10ps

module macro_instr_select #(
   parameter int LC_WIDTH = $bits(macro_fetch_pkg::lc_t),
   parameter int WORD_WIDTH = $bits(macro_fetch_pkg::mem_word_t)
) (
   lc_bus_if.reader lcb,
   input logic [WORD_WIDTH-1:0] word,
   output logic [WORD_WIDTH/2-1:0] macro_instr
);

   localparam int HALF_WIDTH = WORD_WIDTH / macro_fetch_pkg::HALVES_PER_WORD;
   localparam int BYTE_WIDTH = WORD_WIDTH / macro_fetch_pkg::BYTES_PER_WORD;

   logic [LC_WIDTH-1:0] lc_cur;
   logic [1:0] byte_index;
   logic [HALF_WIDTH-1:0] half_sel;
   logic [BYTE_WIDTH-1:0] byte_sel;

   assign lc_cur = lcb.lc;
   assign byte_index = lc_cur[1:0];

   // lc[1] picks the half, low half first.
   assign half_sel = lc_cur[1] ? word[WORD_WIDTH-1:HALF_WIDTH] : word[HALF_WIDTH-1:0];

   assign byte_sel = word[byte_index*BYTE_WIDTH +: BYTE_WIDTH];

   always_comb
   begin
      if (lcb.lc_byte_mode)
         macro_instr = {{(HALF_WIDTH-BYTE_WIDTH){1'b0}}, byte_sel};   // zero extended.
      else
         macro_instr = half_sel;
   end

endmodule

/* sim.f */
logic/macro_fetch_pkg.sv
logic/lc_bus_if.sv
logic/lc_control.sv
logic/location_counter.sv
logic/instruction_word_buffer.sv
logic/macro_instr_select.sv
logic/macro_fetch_unit.sv
verification/macro_fetch_unit_tb.sv

/* verification/macro_fetch_unit_tb.sv */
// Macro fetch unit testbench

`timescale 1ns/10ps

module macro_fetch_unit_tb;

   localparam int WAIT_LIMIT = 20;   // cycles, longer than any memory delay.

   logic clk;
   logic reset;
   logic state_fetch;
   logic destlc;
   macro_fetch_pkg::lc_t lc_load_data;
   logic byte_mode;
   logic irdisp;
   logic spop;
   logic srcspcpopreal;
   logic ext_int;
   logic bus_int;
   macro_fetch_pkg::ir_t ir;
   macro_fetch_pkg::spc_t spc;
   logic mem_valid;
   macro_fetch_pkg::mem_word_t mem_data;
   logic mem_rd;
   macro_fetch_pkg::word_addr_t mem_addr;
   macro_fetch_pkg::macro_instr_t macro_instr;
   logic word_valid;
   macro_fetch_pkg::lc_t lc;
   logic needfetch;
   logic lcinc;
   logic ifetch;
   logic newlc;
   logic sintr;
   logic spc1a;
   logic inst_in_left_half;
   logic sh3;
   logic sh4;

   int error_count = 0;
   int rd_count = 0;                  // mem_rd pulses seen by the memory.
   macro_fetch_pkg::word_addr_t rd_addr;
   logic [31:0] rng_state = 32'h186bcfd1;

   // expected lc state.
   macro_fetch_pkg::lc_t model_lc = '0;
   logic model_byte_mode = 1'b0;
   logic model_newlc = 1'b0;
   logic model_next_instr = 1'b0;
   logic model_sintr = 1'b0;
   macro_fetch_pkg::mem_word_t model_word = '0;

   macro_fetch_unit #(
      .LC_WIDTH($bits(macro_fetch_pkg::lc_t)),
      .WORD_WIDTH($bits(macro_fetch_pkg::mem_word_t))
   ) uut (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // every byte of the word changes with the address.
   function automatic macro_fetch_pkg::mem_word_t word_at(input macro_fetch_pkg::word_addr_t a);
      return {a[23:16] ^ 8'h1e, a[15:8] ^ 8'h2d, a[7:0] ^ 8'h4b, a[23:16] ^ a[7:0] ^ 8'h87};
   endfunction

   function automatic macro_fetch_pkg::macro_instr_t select_instr(
      input macro_fetch_pkg::mem_word_t w, input macro_fetch_pkg::lc_t l, input logic bm);
      if (bm)
         return {8'h00, w[8*l[1:0] +: 8]};   // byte 0 at the low end.
      return l[1] ? w[31:16] : w[15:0];
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         error_count++;
         $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
         $display("Finished with errors");
         $fatal(1);
      end
   endtask

   // memory answers each read after 1 to 6 cycles.
   initial
   begin
      mem_valid = 1'b0;
      mem_data = '0;
      forever
      begin
         @(negedge clk);
         if (mem_rd)
         begin
            rd_count++;
            rd_addr = mem_addr;
            rng_state = next_random(rng_state);
            repeat (rng_state % 6 + 1) @(posedge clk);
            mem_valid <= 1'b1;
            mem_data <= word_at(rd_addr);
            @(posedge clk);
            mem_valid <= 1'b0;
         end
      end
   end

   // one microinstruction ending in a state_fetch strobe.
   task automatic run_step(input logic load, input macro_fetch_pkg::lc_t value,
                           input logic bm, input logic disp);
      logic lcinc_exp;
      logic fetch_exp;
      int rd_before;
      int cycles;
      lcinc_exp = model_next_instr | (disp & ir[macro_fetch_pkg::IR_LCINC_BIT]);
      fetch_exp = lcinc_exp & (model_newlc | load
                               | (!model_lc[1] & !(model_lc[0] & model_byte_mode)));
      rd_before = rd_count;
      cycles = 0;
      @(posedge clk);
      state_fetch <= 1'b1;
      destlc <= load;
      lc_load_data <= value;
      byte_mode <= bm;
      irdisp <= disp;
      @(negedge clk);
      check_value("lcinc", 32'(lcinc), 32'(lcinc_exp));
      check_value("ifetch", 32'(ifetch), 32'(fetch_exp));
      @(posedge clk);
      state_fetch <= 1'b0;
      destlc <= 1'b0;
      irdisp <= 1'b0;
      model_newlc = (model_newlc | load) & !lcinc_exp;
      model_next_instr = spop & !srcspcpopreal & spc[macro_fetch_pkg::SPC_MACRO_RETURN_BIT];
      model_sintr = ext_int | bus_int;
      if (load)
      begin
         model_lc = value;
         model_byte_mode = bm;
      end
      else if (lcinc_exp)
         model_lc = model_lc + (model_byte_mode ? 26'd1 : 26'd2);
      @(negedge clk);
      if (fetch_exp)
      begin
         while (!word_valid && cycles < WAIT_LIMIT)
         begin
            @(negedge clk);
            cycles++;
         end
         if (!word_valid)
         begin
            $display("Timeout: word_valid never rose after a fetch");
            $display("Finished with errors");
            $fatal(1);
         end
         check_value("mem_rd count", 32'(rd_count - rd_before), 32'd1);
         check_value("mem_addr", 32'(mem_addr), 32'(model_lc[25:2]));
         model_word = word_at(model_lc[25:2]);
      end
      check_value("word_valid", 32'(word_valid), 32'd1);   // a stray fetch drops it.
      check_value("lc", 32'(lc), 32'(model_lc));
      check_value("newlc", 32'(newlc), 32'(model_newlc));
      check_value("sintr", 32'(sintr), 32'(model_sintr));
      check_value("macro_instr", 32'(macro_instr),
                  32'(select_instr(model_word, model_lc, model_byte_mode)));
   endtask

   task automatic load_and_fetch();
      int rd_before;
      run_step(1'b1, 26'h1234a58, 1'b0, 1'b1);
      rd_before = rd_count;
      repeat (4) @(negedge clk);
      check_value("mem_rd count", 32'(rd_count), 32'(rd_before));
   endtask

   task automatic walk_lc(input macro_fetch_pkg::lc_t start, input logic bm, input int steps);
      run_step(1'b1, start, bm, 1'b1);
      repeat (steps) run_step(1'b0, '0, bm, 1'b1);
   endtask

   task automatic interrupt_sampling();
      for (int k = 0; k < 4; k++)
      begin
         @(posedge clk);
         ext_int <= k[0];
         bus_int <= k[1];
         run_step(1'b0, '0, model_byte_mode, 1'b0);
         @(posedge clk);
         ext_int <= !k[0];   // between strobes, must not show.
         bus_int <= !k[1];
         repeat (2) @(negedge clk);
         check_value("sintr", 32'(sintr), 32'(k[0] | k[1]));
      end
   endtask

   task automatic rotation_adjust();
      macro_fetch_pkg::ir_t ir_value;
      logic both;
      logic left;
      logic quarter;
      for (int bm = 0; bm < 2; bm++)
         for (int low = 0; low < 4; low++)
            if (bm == 1 || low[0] == 1'b0)
            begin
               run_step(1'b1, {24'h2af37c, low[1:0]}, bm[0], 1'b0);
               for (int rot = 0; rot < 4; rot++)
               begin
                  ir_value = '0;
                  ir_value[macro_fetch_pkg::IR_MROT_BIT_A] = rot[0];
                  ir_value[macro_fetch_pkg::IR_MROT_BIT_B] = rot[1];
                  ir_value[4:3] = low[1:0] ^ 2'b10;
                  both = rot[0] & rot[1];   // one bit alone leaves ir as is.
                  // bytes run 0, 3, 2, 1 from the left, halfword 0 is left.
                  left = both & (bm[0] ? (low == 0 || low == 3) : !low[1]);
                  quarter = both & bm[0] & !low[0];   // bytes 0 and 2.
                  @(posedge clk);
                  ir <= ir_value;
                  @(negedge clk);
                  check_value("inst_in_left_half", 32'(inst_in_left_half), 32'(left));
                  check_value("sh4", 32'(sh4), 32'(ir_value[4] ^ left));
                  check_value("sh3", 32'(sh3), 32'(ir_value[3] ^ quarter));
               end
            end
      @(posedge clk);
      ir <= macro_fetch_pkg::ir_t'(1) << macro_fetch_pkg::IR_LCINC_BIT;
   endtask

   task automatic spc1a_rule();
      macro_fetch_pkg::spc_t spc_value;
      logic need;
      for (int k = 0; k < 4; k++)
      begin
         spc_value = '0;
         spc_value[1] = k[0];
         spc_value[macro_fetch_pkg::SPC_MACRO_RETURN_BIT] = k[1];
         @(posedge clk);
         spc <= spc_value;
         @(negedge clk);
         need = model_newlc | (!model_lc[1] & !(model_lc[0] & model_byte_mode));
         check_value("needfetch", 32'(needfetch), 32'(need));
         check_value("spc1a", 32'(spc1a), 32'((k[1] & !need) | k[0]));
      end
   endtask

   task automatic macro_return();
      @(posedge clk);
      spc <= macro_fetch_pkg::spc_t'(1) << macro_fetch_pkg::SPC_MACRO_RETURN_BIT;
      spop <= 1'b1;
      srcspcpopreal <= 1'b0;
      run_step(1'b0, '0, model_byte_mode, 1'b0);
      @(posedge clk);
      spop <= 1'b0;
      @(negedge clk);
      check_value("lcinc after return", 32'(lcinc), 32'd1);
      run_step(1'b0, '0, model_byte_mode, 1'b0);
      spc1a_rule();
      run_step(1'b0, '0, model_byte_mode, 1'b1);
      spc1a_rule();
      @(posedge clk);
      spop <= 1'b1;      // a real pop stays in microcode.
      srcspcpopreal <= 1'b1;
      run_step(1'b0, '0, model_byte_mode, 1'b0);
      @(posedge clk);
      spop <= 1'b0;
      srcspcpopreal <= 1'b0;
      @(negedge clk);
      check_value("lcinc after real pop", 32'(lcinc), 32'd0);
   endtask

   initial
   begin
      reset = 1'b1;
      state_fetch = 1'b0;
      destlc = 1'b0;
      lc_load_data = '0;
      byte_mode = 1'b0;
      irdisp = 1'b0;
      spop = 1'b0;
      srcspcpopreal = 1'b0;
      ext_int = 1'b0;
      bus_int = 1'b0;
      ir = macro_fetch_pkg::ir_t'(1) << macro_fetch_pkg::IR_LCINC_BIT;
      spc = '0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("lc", 32'(lc), 32'd0);
      check_value("word_valid", 32'(word_valid), 32'd0);
      load_and_fetch();
      walk_lc(26'h002468a, 1'b0, 7);   // halfword mode.
      walk_lc(26'h0135791, 1'b1, 10);  // byte mode.
      interrupt_sampling();
      rotation_adjust();
      macro_return();
      if (error_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule
